/* verilog/stoch_pkg.sv */
`default_nettype none

package stoch_pkg;

   // lane count and operand size
   localparam int LANES    = 4;
   localparam int OP_WIDTH = 4;

   // one unary stream is a full ramp period
   localparam int SEQ_LEN    = 2 ** OP_WIDTH;
   localparam int MUL_CYCLES = SEQ_LEN * SEQ_LEN;  // a replayed SEQ_LEN times

   // result widths
   localparam int PROD_WIDTH = 2 * OP_WIDTH;  // 15*15 = 225
   localparam int DOT_WIDTH  = 10;            // 4*225 = 900

   // sequencer phase codes
   localparam logic [1:0] PH_IDLE = 2'd0;
   localparam logic [1:0] PH_LOAD = 2'd1;  // a streams into the buffer
   localparam logic [1:0] PH_MUL  = 2'd2;  // replay and count

endpackage

`default_nettype wire

/* verilog/sn_comparator.sv */
`timescale 1ns/10ps
`default_nettype none

module sn_comparator (
   input  logic [stoch_pkg::OP_WIDTH-1:0] a,
   input  logic [stoch_pkg::OP_WIDTH-1:0] b,
   output logic                           a_gt_b
);
   import stoch_pkg::*;

   logic [OP_WIDTH-1:1] eq;      // per-bit equal, lsb never gates anything
   logic [OP_WIDTH-1:0] agt;     // per-bit a larger
   logic [OP_WIDTH-1:0] eq_pre;  // all bits above this one equal

   assign eq  = ~(a[OP_WIDTH-1:1] ^ b[OP_WIDTH-1:1]);
   assign agt = a & ~b;

   assign eq_pre[OP_WIDTH-1] = 1'b1;
   for (genvar i = OP_WIDTH - 2; i >= 0; i--) begin : g_chain
      assign eq_pre[i] = eq_pre[i+1] & eq[i+1];
   end

   // first differing bit from the msb decides
   assign a_gt_b = |(agt & eq_pre);

endmodule

`default_nettype wire

/* verilog/sn_generator.sv */
`timescale 1ns/10ps
`default_nettype none

module sn_generator (
   input  logic                                          clk,
   input  logic                                          rst,
   input  logic                                          start,
   input  logic [stoch_pkg::LANES*stoch_pkg::OP_WIDTH-1:0] a_ops,
   input  logic [stoch_pkg::LANES*stoch_pkg::OP_WIDTH-1:0] b_ops,
   output logic                                          busy,
   output logic [stoch_pkg::LANES-1:0]                   load_bits,
   output logic [stoch_pkg::LANES-1:0]                   b_bits,
   output logic                                          shift_en,
   output logic                                          wrap,
   output logic                                          mul_en,
   output logic                                          mul_last,
   output logic                                          clear
);
   import stoch_pkg::*;

   logic [1:0]                phase;
   logic [LANES*OP_WIDTH-1:0] a_reg;
   logic [LANES*OP_WIDTH-1:0] b_reg;
   logic [OP_WIDTH-1:0]       ramp;   // fast counter, one step per cycle
   logic [OP_WIDTH-1:0]       slow;   // steps once per ramp wrap
   logic                      ramp_wrap;
   logic                      slow_wrap;
   logic                      accept;

   assign accept    = start & (phase == PH_IDLE);  // start while busy is dropped
   assign ramp_wrap = &ramp;
   assign slow_wrap = &slow;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         phase <= PH_IDLE;
         ramp  <= '0;
         slow  <= '0;
         clear <= 1'b0;
      end else begin
         clear <= accept;
         case (phase)
            PH_IDLE: begin
               if (accept) begin
                  phase <= PH_LOAD;
                  ramp  <= '0;
                  slow  <= '0;
               end
            end
            PH_LOAD: begin
               ramp <= ramp + 1'b1;
               if (ramp_wrap)
                  phase <= PH_MUL;  // one full ramp period loaded
            end
            PH_MUL: begin
               ramp <= ramp + 1'b1;
               if (ramp_wrap) begin
                  slow <= slow + 1'b1;
                  if (slow_wrap)
                     phase <= PH_IDLE;
               end
            end
            default: phase <= PH_IDLE;
         endcase
      end
   end

   // operands only sampled on an accepted start
   always_ff @(posedge clk) begin
      if (accept) begin
         a_reg <= a_ops;
         b_reg <= b_ops;
      end
   end

   assign busy     = (phase != PH_IDLE);
   assign shift_en = (phase == PH_LOAD) | (phase == PH_MUL);
   assign wrap     = (phase == PH_MUL);  // buffer recirculates
   assign mul_en   = (phase == PH_MUL);
   assign mul_last = ramp_wrap & slow_wrap;  // both counters rest at zero when idle

   // a stream against ramp, b stream against slow
   for (genvar i = 0; i < LANES; i++) begin : g_lane
      sn_comparator u_cmp_a (
         .a      (a_reg[i*OP_WIDTH +: OP_WIDTH]),
         .b      (ramp),
         .a_gt_b (load_bits[i])
      );

      sn_comparator u_cmp_b (
         .a      (b_reg[i*OP_WIDTH +: OP_WIDTH]),
         .b      (slow),
         .a_gt_b (b_bits[i])
      );
   end

   a_no_clear_in_mul: assert property (
      @(posedge clk) disable iff (rst) clear |-> (phase != PH_MUL)
   );

   a_last_in_mul: assert property (
      @(posedge clk) disable iff (rst) mul_last |-> mul_en
   );

   // multiply phase always runs its full length
   a_mul_length: assert property (
      @(posedge clk) disable iff (rst) $rose(mul_en) |-> ##(MUL_CYCLES - 1) mul_last
   );

endmodule

`default_nettype wire

/* verilog/stream_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module stream_buffer (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        shift_en,
   input  logic                        wrap,
   input  logic [stoch_pkg::LANES-1:0] load_bits,
   output logic [stoch_pkg::LANES-1:0] rep_bits
);
   import stoch_pkg::*;

   logic [SEQ_LEN-1:0] sreg [LANES];
   logic [LANES-1:0]   ser_in;

   // serial input, fresh bit or recirculated top bit
   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         ser_in[i] = wrap ? sreg[i][SEQ_LEN-1] : load_bits[i];
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < LANES; i++) begin
            sreg[i] <= '0;
         end
      end else if (shift_en) begin
         for (int i = 0; i < LANES; i++) begin
            sreg[i] <= {sreg[i][SEQ_LEN-2:0], ser_in[i]};  // shift toward msb
         end
      end
   end

   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         rep_bits[i] = sreg[i][SEQ_LEN-1];
      end
   end

   // replay only makes sense on a register that keeps moving
   a_wrap_shifts: assert property (
      @(posedge clk) disable iff (rst) $rose(wrap) |-> shift_en
   );

endmodule

`default_nettype wire

/* verilog/ones_counter_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module ones_counter_bank (
   input  logic                                             clk,
   input  logic                                             rst,
   input  logic                                             clear,
   input  logic                                             mul_en,
   input  logic                                             mul_last,
   input  logic [stoch_pkg::LANES-1:0]                      rep_bits,
   input  logic [stoch_pkg::LANES-1:0]                      b_bits,
   output logic [stoch_pkg::LANES*stoch_pkg::PROD_WIDTH-1:0] products,
   output logic [stoch_pkg::DOT_WIDTH-1:0]                  dot,
   output logic                                             done
);
   import stoch_pkg::*;

   logic [LANES-1:0]      hit;  // stochastic product bits
   logic [PROD_WIDTH-1:0] cnt      [LANES];
   logic [PROD_WIDTH-1:0] cnt_next [LANES];
   logic [DOT_WIDTH-1:0]  dot_sum;

   assign hit = rep_bits & b_bits & {LANES{mul_en}};

   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         cnt_next[i] = cnt[i] + PROD_WIDTH'(hit[i]);
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < LANES; i++) begin
            cnt[i] <= '0;
         end
      end else if (clear) begin
         for (int i = 0; i < LANES; i++) begin
            cnt[i] <= '0;
         end
      end else begin
         for (int i = 0; i < LANES; i++) begin
            if (hit[i])
               cnt[i] <= cnt_next[i];
         end
      end
   end

   // sum of the next counts so the final bit is included
   always_comb begin
      dot_sum = '0;
      for (int i = 0; i < LANES; i++) begin
         dot_sum = dot_sum + DOT_WIDTH'(cnt_next[i]);
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         dot  <= '0;
         done <= 1'b0;
      end else begin
         done <= mul_last;
         if (clear)
            dot <= '0;
         else if (mul_last)
            dot <= dot_sum;
      end
   end

   always_comb begin
      for (int i = 0; i < LANES; i++) begin
         products[i*PROD_WIDTH +: PROD_WIDTH] = cnt[i];
      end
   end

   // a 16x16 replay can never exceed 15*15 ones
   for (genvar i = 0; i < LANES; i++) begin : g_chk
      a_cnt_max: assert property (
         @(posedge clk) disable iff (rst) cnt[i] <= (SEQ_LEN - 1) * (SEQ_LEN - 1)
      );
   end

   a_done_pulse: assert property (
      @(posedge clk) disable iff (rst) done |=> !done
   );

endmodule

`default_nettype wire

/* verilog/stoch_mac_top.sv */
`timescale 1ns/10ps
`default_nettype none

module stoch_mac_top (
   input  logic                                             clk,
   input  logic                                             rst,
   input  logic                                             start,
   input  logic [stoch_pkg::LANES*stoch_pkg::OP_WIDTH-1:0]   a_ops,
   input  logic [stoch_pkg::LANES*stoch_pkg::OP_WIDTH-1:0]   b_ops,
   output logic                                             busy,
   output logic                                             done,
   output logic [stoch_pkg::LANES*stoch_pkg::PROD_WIDTH-1:0] products,
   output logic [stoch_pkg::DOT_WIDTH-1:0]                  dot
);
   import stoch_pkg::*;

   logic [LANES-1:0] load_bits;
   logic [LANES-1:0] rep_bits;
   logic [LANES-1:0] b_bits;
   logic             shift_en;
   logic             wrap;
   logic             mul_en;
   logic             mul_last;
   logic             clear;

   // producer, sequencer and stream generation
   sn_generator u_gen (
      .clk       (clk),
      .rst       (rst),
      .start     (start),
      .a_ops     (a_ops),
      .b_ops     (b_ops),
      .busy      (busy),
      .load_bits (load_bits),
      .b_bits    (b_bits),
      .shift_en  (shift_en),
      .wrap      (wrap),
      .mul_en    (mul_en),
      .mul_last  (mul_last),
      .clear     (clear)
   );

   stream_buffer u_buf (
      .clk       (clk),
      .rst       (rst),
      .shift_en  (shift_en),
      .wrap      (wrap),
      .load_bits (load_bits),
      .rep_bits  (rep_bits)
   );

   // consumer, and gates plus counters
   ones_counter_bank u_bank (
      .clk      (clk),
      .rst      (rst),
      .clear    (clear),
      .mul_en   (mul_en),
      .mul_last (mul_last),
      .rep_bits (rep_bits),
      .b_bits   (b_bits),
      .products (products),
      .dot      (dot),
      .done     (done)
   );

endmodule

`default_nettype wire

/* test/stoch_mac_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module stoch_mac_tb;
   import stoch_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int RST_CYCLES = 10;
   localparam int N_VEC      = 18;   // lines in the stimulus file
   localparam int N_RAND     = 8;
   localparam int LATENCY    = 272;  // start edge to done edge
   localparam int RUN_LIMIT  = 300;
   localparam int HOLD_CYCLES = 20;
   localparam int WATCHDOG_CYCLES = (N_VEC + N_RAND + 2) * 300 + RST_CYCLES;

   logic                             clk = 1'b0;
   logic                             rst;
   logic                             start;
   logic [LANES*OP_WIDTH-1:0]        a_ops;
   logic [LANES*OP_WIDTH-1:0]        b_ops;
   logic                             busy;
   logic                             done;
   logic [LANES*PROD_WIDTH-1:0]      products;
   logic [DOT_WIDTH-1:0]             dot;

   logic [31:0] vec_mem [0:N_VEC*4-1];  // a, b, products, dot per test
   int          edge_cnt = 0;
   int          errors = 0;
   int          checks = 0;

   stoch_mac_top DUT (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .a_ops    (a_ops),
      .b_ops    (b_ops),
      .busy     (busy),
      .done     (done),
      .products (products),
      .dot      (dot)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) edge_cnt <= edge_cnt + 1;  // rising edge index

   // unary stream product is exact, a*b per lane
   function automatic logic [31:0] rule_products(input logic [15:0] a, input logic [15:0] b);
      logic [31:0] p;
      p = '0;
      for (int i = 0; i < LANES; i++) begin
         p[i*PROD_WIDTH +: PROD_WIDTH] = a[i*OP_WIDTH +: OP_WIDTH] * b[i*OP_WIDTH +: OP_WIDTH];
      end
      return p;
   endfunction

   function automatic logic [9:0] rule_dot(input logic [31:0] p);
      logic [9:0] s;
      s = '0;
      for (int i = 0; i < LANES; i++) begin
         s = s + 10'(p[i*PROD_WIDTH +: PROD_WIDTH]);
      end
      return s;
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp_val,
                              input logic [31:0] act_val);
      checks++;
      assert (act_val === exp_val)
      else begin
         $display("ERR %s expected %h got %h at %0t", name, exp_val, act_val, $time);
         errors++;
      end
   endtask

   task automatic check_true(input bit cond, input string what);
      checks++;
      assert (cond)
      else begin
         $display("%s at %0t", what, $time);
         errors++;
      end
   endtask

   // one full run, optionally with a second start while busy
   task automatic run_mac(input logic [15:0] a, input logic [15:0] b,
                          input logic [31:0] exp_prod, input logic [9:0] exp_dot,
                          input bit poke_busy);
      int  start_edge;
      int  waited;
      bit  seen_done;
      @(negedge clk);
      check_value("busy", 0, busy);
      a_ops = a;
      b_ops = b;
      start = 1'b1;
      start_edge = edge_cnt + 1;  // next rising edge samples start
      @(negedge clk);
      start = 1'b0;
      waited = 0;
      seen_done = 0;
      while (!seen_done && waited < RUN_LIMIT) begin
         if (done) begin
            seen_done = 1;
         end else begin
            check_value("busy", 1, busy);
            start = poke_busy && (waited == 40);
            if (start) begin
               a_ops = ~a;  // must not be captured
               b_ops = ~b;
            end
            @(negedge clk);
            waited++;
         end
      end
      start = 1'b0;
      check_true(seen_done, "done never arrived after start");
      if (seen_done) begin
         check_value("latency", LATENCY, edge_cnt - start_edge);
         check_value("busy", 0, busy);
         check_value("products", exp_prod, products);
         check_value("dot", {22'd0, exp_dot}, {22'd0, dot});
         @(negedge clk);
         check_value("done", 0, done);  // one cycle only
      end
   endtask

   // results stay put while idle, whatever the operand inputs do
   task automatic check_hold(input logic [31:0] exp_prod, input logic [9:0] exp_dot);
      for (int i = 0; i < HOLD_CYCLES; i++) begin
         @(negedge clk);
         a_ops = a_ops + 16'h1357;
         b_ops = b_ops ^ 16'hA5C3;
         check_value("products", exp_prod, products);
         check_value("dot", {22'd0, exp_dot}, {22'd0, dot});
         check_value("busy", 0, busy);
      end
   endtask

   initial begin
      logic [15:0] a;
      logic [15:0] b;
      logic [31:0] fp;
      logic [31:0] rp;
      logic [9:0]  rd;
      logic [31:0] rnd;
      int          seed;
      rst = 1'b1;
      start = 1'b0;
      a_ops = '0;
      b_ops = '0;
      seed = 32'h9829;
      $readmemh("test/stoch_mac_stimulus.txt", vec_mem);
      repeat (RST_CYCLES) @(negedge clk);
      rst = 1'b0;

      @(negedge clk);
      check_value("busy", 0, busy);
      check_value("done", 0, done);
      check_value("products", 0, products);
      check_value("dot", 0, dot);

      for (int v = 0; v < N_VEC; v++) begin
         a  = vec_mem[4*v][15:0];
         b  = vec_mem[4*v+1][15:0];
         fp = vec_mem[4*v+2];
         rp = rule_products(a, b);
         rd = rule_dot(rp);
         check_true(fp === rp && vec_mem[4*v+3] === {22'd0, rd},
                    $sformatf("stimulus line %0d does not follow the a*b rule", v));
         run_mac(a, b, fp, vec_mem[4*v+3][9:0], 0);
         if (v == 1)
            check_hold(fp, vec_mem[4*v+3][9:0]);
      end

      // second start mid run is dropped
      rp = rule_products(16'h9C3E, 16'h47A5);
      run_mac(16'h9C3E, 16'h47A5, rp, rule_dot(rp), 1);

      for (int r = 0; r < N_RAND; r++) begin
         rnd = $random(seed);
         a = rnd[15:0];
         b = rnd[31:16];
         rp = rule_products(a, b);
         run_mac(a, b, rp, rule_dot(rp), 0);
      end

      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0)
         $display("Result: PASSED");
      else
         $display("Result: FAILED");
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: the test sequence did not finish in time");
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* Bender.yml */
package:
  name: stoch_mac

sources:
  # package first, then leaf modules up to the top
  - files:
      - verilog/stoch_pkg.sv
      - verilog/sn_comparator.sv
      - verilog/sn_generator.sv
      - verilog/stream_buffer.sv
      - verilog/ones_counter_bank.sv
      - verilog/stoch_mac_top.sv

  # self-checking testbench, top module stoch_mac_tb
  - target: test
    files:
      - test/stoch_mac_tb.sv

/* stoch_mac_top.f */
verilog/stoch_pkg.sv
verilog/sn_comparator.sv
verilog/sn_generator.sv
verilog/stream_buffer.sv
verilog/ones_counter_bank.sv
verilog/stoch_mac_top.sv
test/stoch_mac_tb.sv

/* test/stoch_mac_stimulus.txt */
// columns: a_ops b_ops products dot, lane 0 in the low nibble and low byte
// products hold a*b per lane, dot is the sum of the four products
0000 0000 00000000 000
FFFF FFFF E1E1E1E1 384
FFFF 0000 00000000 000
0000 FFFF 00000000 000
F0F0 0FF0 0000E100 0E1
1111 1111 01010101 004
1234 4321 04060604 014
8888 8888 40404040 100
F1F1 1F1F 0F0F0F0F 03C
7777 9999 3F3F3F3F 0FC
ABCD EF01 8CA5000D 13E
5A3C C3A5 3C1E1E3C 0B4
0F0F F0F0 00000000 000
FEDC 2345 1E2A343C 0B8
E0F1 FEF0 D200E100 1B3
6969 9696 36363636 0D8
2468 8642 10181810 050
D7B3 5E29 4162161B 0D4
